/* hdl/dma_defines.svh */
// Width and depth macros for the DMA copy engine.
`ifndef DMA_DEFINES_SVH
`define DMA_DEFINES_SVH

`define DMA_ADDR_W 32      // byte address width.
`define DMA_DATA_W 64      // one data beat, a full word.
`define DMA_LEN_W 8        // burst length in beats, zero encodes 256.
`define DMA_TAG_W 4        // descriptor tag width.

`define DMA_DESC_DEPTH 4   // descriptor queue entries.
`define DMA_DATA_DEPTH 8   // data beats buffered between the two sequencers.

`endif

/* hdl/dma_pkg.sv */
// Types for the DMA copy engine: descriptor, memory channel payloads,
// completion and status records, and the sequencer state enums.
`default_nettype none

`include "dma_defines.svh"

package dma_pkg;

   typedef struct packed {
      logic [`DMA_ADDR_W-1:0] src_addr;
      logic [`DMA_ADDR_W-1:0] dst_addr;
      logic [`DMA_LEN_W-1:0]  length;    // beats, zero means 256.
      logic [`DMA_TAG_W-1:0]  tag;
   } t_dma_descriptor;

   typedef struct packed {
      logic [`DMA_ADDR_W-1:0] addr;
      logic [`DMA_LEN_W-1:0]  len;       // beats minus one.
   } t_mem_ar;

   typedef struct packed {
      logic [`DMA_DATA_W-1:0] data;
      logic                   last;
   } t_mem_r;

   typedef struct packed {
      logic [`DMA_ADDR_W-1:0] addr;
      logic [`DMA_LEN_W-1:0]  len;
   } t_mem_aw;

   typedef struct packed {
      logic [`DMA_DATA_W-1:0] data;
      logic                   last;
   } t_mem_w;

   typedef struct packed {
      logic [`DMA_TAG_W-1:0] tag;
   } t_dma_done;

   typedef struct packed {
      logic       busy;
      logic [7:0] completed;
   } t_dma_status;

   typedef enum logic [1:0] {
      RD_IDLE,
      RD_ADDR_SETUP,
      RD_COPY_TO_FIFO,
      RD_WAIT_FOR_WR
   } t_rd_state;

   typedef enum logic [1:0] {
      WR_IDLE,
      WR_ADDR_SETUP,
      WR_COPY_FROM_FIFO,
      WR_WAIT_FOR_RESP
   } t_wr_state;

endpackage

`default_nettype wire

/* hdl/dma_sync_fifo.sv */
// Synchronous circular-buffer FIFO with a combinational head output.
`timescale 1ns/100ps
`default_nettype none

module dma_sync_fifo #(
   parameter int WIDTH = 64,
   parameter int DEPTH = 8
)(
   input  wire logic             clk,
   input  wire logic             reset_n,
   input  wire logic             push,
   input  wire logic [WIDTH-1:0] push_data,
   output logic                  full,
   input  wire logic             pop,
   output logic      [WIDTH-1:0] pop_data,
   output logic                  not_empty
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   logic [WIDTH-1:0] mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             do_push;
   logic             do_pop;

   assign full      = (count == CNT_W'(DEPTH));
   assign not_empty = (count != '0);
   assign pop_data  = mem[rd_ptr];

   assign do_push = push && !full;       // a push into a full FIFO is dropped.
   assign do_pop  = pop && not_empty;

   always_ff @(posedge clk) begin
      if (do_push) mem[wr_ptr] <= push_data;
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (do_pop)  rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         if (do_push && !do_pop)      count <= count + 1'b1;
         else if (do_pop && !do_push) count <= count - 1'b1;
      end
   end

endmodule

`default_nettype wire

/* hdl/dma_read_fsm.sv */
// Read sequencer: source burst read into the data FIFO, and release of the
// descriptor once the write side has completed.
`timescale 1ns/100ps
`default_nettype none

`include "dma_defines.svh"

module dma_read_fsm
   import dma_pkg::*;
(
   input  wire logic                  clk,
   input  wire logic                  reset_n,
   input  wire t_dma_descriptor       desc_head,
   input  wire logic                  desc_not_empty,
   output logic                       desc_pop,
   output logic                       ar_valid,
   input  wire logic                  ar_ready,
   output t_mem_ar                    ar,
   input  wire logic                  r_valid,
   output logic                       r_ready,
   input  wire t_mem_r                r,
   input  wire logic                  fifo_full,
   output logic                       fifo_push,
   output logic [`DMA_DATA_W-1:0]     fifo_data,
   input  wire logic                  wr_done,
   output logic                       rd_started,
   output logic                       busy
);

   t_rd_state state;
   t_rd_state next;

   always_ff @(posedge clk) begin
      if (!reset_n) state <= RD_IDLE;
      else          state <= next;
   end

   always_comb begin
      next = state;
      unique case (state)
         RD_IDLE: begin
            if (desc_not_empty) next = RD_ADDR_SETUP;
         end
         RD_ADDR_SETUP: begin
            if (ar_ready) next = RD_COPY_TO_FIFO;
         end
         RD_COPY_TO_FIFO: begin
            if (r_valid && r_ready && r.last) next = RD_WAIT_FOR_WR;
         end
         RD_WAIT_FOR_WR: begin
            if (wr_done) next = RD_IDLE;
         end
         default: next = RD_IDLE;
      endcase
   end

   // the head stays in the queue until the pop, so ar is stable while valid.
   assign ar_valid = (state == RD_ADDR_SETUP);
   assign ar.addr  = desc_head.src_addr;
   assign ar.len   = desc_head.length - 1'b1;

   assign rd_started = ar_valid && ar_ready;   // kicks off the write sequencer.

   // beats are only accepted while the data FIFO has room.
   assign r_ready   = (state == RD_COPY_TO_FIFO) && !fifo_full;
   assign fifo_push = r_valid && r_ready;
   assign fifo_data = r.data;

   assign desc_pop = (state == RD_WAIT_FOR_WR) && wr_done;
   assign busy     = (state != RD_IDLE);

endmodule

`default_nettype wire

/* hdl/dma_write_fsm.sv */
// Write sequencer: destination burst write from the data FIFO, completion
// record and completed count.
`timescale 1ns/100ps
`default_nettype none

`include "dma_defines.svh"

module dma_write_fsm
   import dma_pkg::*;
(
   input  wire logic                  clk,
   input  wire logic                  reset_n,
   input  wire t_dma_descriptor       desc_head,
   input  wire logic                  rd_started,
   input  wire logic [`DMA_DATA_W-1:0] fifo_data,
   input  wire logic                  fifo_not_empty,
   output logic                       fifo_pop,
   output logic                       aw_valid,
   input  wire logic                  aw_ready,
   output t_mem_aw                    aw,
   output logic                       w_valid,
   input  wire logic                  w_ready,
   output t_mem_w                     w,
   input  wire logic                  b_valid,
   output logic                       b_ready,
   output logic                       done_valid,
   output t_dma_done                  done,
   output logic                       wr_done,
   output logic [7:0]                 completed
);

   t_wr_state              state;
   t_wr_state              next;
   logic [`DMA_LEN_W-1:0]  beat_cnt;
   logic                   w_fire;
   logic                   b_fire;

   assign w_fire = w_valid && w_ready;
   assign b_fire = b_valid && b_ready;

   always_ff @(posedge clk) begin
      if (!reset_n) state <= WR_IDLE;
      else          state <= next;
   end

   always_comb begin
      next = state;
      unique case (state)
         WR_IDLE: begin
            if (rd_started) next = WR_ADDR_SETUP;
         end
         WR_ADDR_SETUP: begin
            if (aw_ready) next = WR_COPY_FROM_FIFO;
         end
         WR_COPY_FROM_FIFO: begin
            if (w_fire && w.last) next = WR_WAIT_FOR_RESP;
         end
         WR_WAIT_FOR_RESP: begin
            if (b_valid) next = WR_IDLE;
         end
         default: next = WR_IDLE;
      endcase
   end

   assign aw_valid = (state == WR_ADDR_SETUP);
   assign aw.addr  = desc_head.dst_addr;
   assign aw.len   = desc_head.length - 1'b1;

   // the FIFO head is the write data; it pops as each beat is accepted.
   assign w_valid  = (state == WR_COPY_FROM_FIFO) && fifo_not_empty;
   assign w.data   = fifo_data;
   assign w.last   = (beat_cnt == desc_head.length - 1'b1);
   assign fifo_pop = w_fire;

   assign b_ready = (state == WR_WAIT_FOR_RESP);

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         beat_cnt   <= '0;
         done_valid <= 1'b0;
         completed  <= '0;
      end else begin
         if (state == WR_ADDR_SETUP) beat_cnt <= '0;
         else if (w_fire)            beat_cnt <= beat_cnt + 1'b1;
         done_valid <= b_fire;                   // one pulse per response.
         if (b_fire) completed <= completed + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (b_fire) done.tag <= desc_head.tag;
   end

   // The read side releases the descriptor on the same cycle as the pulse.
   assign wr_done = done_valid;

endmodule

`default_nettype wire

/* hdl/dma_copy_top.sv */
// DMA copy engine top level: descriptor queue, data FIFO and the two sequencers.
`timescale 1ns/100ps
`default_nettype none

`include "dma_defines.svh"

module dma_copy_top
   import dma_pkg::*;
(
   input  wire logic            clk,
   input  wire logic            reset_n,
   input  wire logic            desc_valid,
   output logic                 desc_ready,
   input  wire t_dma_descriptor desc,
   output logic                 ar_valid,
   input  wire logic            ar_ready,
   output t_mem_ar              ar,
   input  wire logic            r_valid,
   output logic                 r_ready,
   input  wire t_mem_r          r,
   output logic                 aw_valid,
   input  wire logic            aw_ready,
   output t_mem_aw              aw,
   output logic                 w_valid,
   input  wire logic            w_ready,
   output t_mem_w               w,
   input  wire logic            b_valid,
   output logic                 b_ready,
   output logic                 done_valid,
   output t_dma_done            done,
   output t_dma_status          status
);

   t_dma_descriptor        desc_head;
   logic                   desc_full;
   logic                   desc_not_empty;
   logic                   desc_pop;
   logic                   data_push;
   logic [`DMA_DATA_W-1:0] data_push_data;
   logic                   data_full;
   logic                   data_pop;
   logic [`DMA_DATA_W-1:0] data_pop_data;
   logic                   data_not_empty;
   logic                   rd_started;
   logic                   wr_done;
   logic                   rd_busy;
   logic [7:0]             completed;

   assign desc_ready = !desc_full;

   dma_sync_fifo #(.WIDTH($bits(t_dma_descriptor)), .DEPTH(`DMA_DESC_DEPTH)) i_desc_fifo (
      .clk, .reset_n,
      .push(desc_valid && desc_ready), .push_data(desc), .full(desc_full),
      .pop(desc_pop), .pop_data(desc_head), .not_empty(desc_not_empty)
   );

   dma_sync_fifo #(.WIDTH(`DMA_DATA_W), .DEPTH(`DMA_DATA_DEPTH)) i_data_fifo (
      .clk, .reset_n,
      .push(data_push), .push_data(data_push_data), .full(data_full),
      .pop(data_pop), .pop_data(data_pop_data), .not_empty(data_not_empty)
   );

   dma_read_fsm i_read_fsm (
      .clk, .reset_n, .desc_head, .desc_not_empty, .desc_pop,
      .ar_valid, .ar_ready, .ar, .r_valid, .r_ready, .r,
      .fifo_full(data_full), .fifo_push(data_push), .fifo_data(data_push_data),
      .wr_done, .rd_started, .busy(rd_busy)
   );

   dma_write_fsm i_write_fsm (
      .clk, .reset_n, .desc_head, .rd_started,
      .fifo_data(data_pop_data), .fifo_not_empty(data_not_empty), .fifo_pop(data_pop),
      .aw_valid, .aw_ready, .aw, .w_valid, .w_ready, .w, .b_valid, .b_ready,
      .done_valid, .done, .wr_done, .completed
   );

   assign status.busy      = rd_busy;   // the read side spans the whole copy.
   assign status.completed = completed;

endmodule

`default_nettype wire

/* verif/dma_copy_chk.sv */
// Handshake assertions for the DMA copy top level, bound into every instance.
`timescale 1ns/100ps
`default_nettype none

module dma_copy_chk
   import dma_pkg::*;
(
   input wire logic        clk,
   input wire logic        reset_n,
   input wire logic        ar_valid,
   input wire logic        ar_ready,
   input wire t_mem_ar     ar,
   input wire logic        aw_valid,
   input wire logic        aw_ready,
   input wire t_mem_aw     aw,
   input wire logic        w_valid,
   input wire logic        w_ready,
   input wire t_mem_w      w,
   input wire logic        r_ready,
   input wire logic        done_valid,
   input wire t_dma_status status
);

   a_ar_hold: assert property (@(posedge clk) disable iff (!reset_n)
      ar_valid && !ar_ready |=> ar_valid && $stable(ar))
      else $error("ar payload or valid changed before ar_ready.");

   a_aw_hold: assert property (@(posedge clk) disable iff (!reset_n)
      aw_valid && !aw_ready |=> aw_valid && $stable(aw))
      else $error("aw payload or valid changed before aw_ready.");

   a_w_hold: assert property (@(posedge clk) disable iff (!reset_n)
      w_valid && !w_ready |=> w_valid && $stable(w))
      else $error("w payload or valid changed before w_ready.");

   a_done_pulse: assert property (@(posedge clk) disable iff (!reset_n)
      done_valid |=> !done_valid)
      else $error("done_valid lasted more than one cycle.");

   a_r_ready_busy: assert property (@(posedge clk) disable iff (!reset_n)
      r_ready |-> status.busy)
      else $error("r_ready high while the engine is idle.");

endmodule

bind dma_copy_top dma_copy_chk i_chk (
   .clk, .reset_n, .ar_valid, .ar_ready, .ar, .aw_valid, .aw_ready, .aw,
   .w_valid, .w_ready, .w, .r_ready, .done_valid, .status
);

`default_nettype wire

/* verif/dma_copy_tb.sv */
// Testbench for the DMA copy engine with the descriptor driver fed from the input
// file, source and destination memory models with random stalls, and the checks.
`timescale 1ns/100ps
`default_nettype none

`include "dma_defines.svh"

module dma_copy_tb
   import dma_pkg::*;
();

   logic            clk = 1'b0;
   logic            reset_n = 1'b0;
   logic            desc_valid = 1'b0;
   logic            desc_ready;
   t_dma_descriptor desc = '0;
   logic            ar_valid;
   logic            ar_ready = 1'b0;
   t_mem_ar         ar;
   logic            r_valid = 1'b0;
   logic            r_ready;
   t_mem_r          r = '0;
   logic            aw_valid;
   logic            aw_ready = 1'b0;
   t_mem_aw         aw;
   logic            w_valid;
   logic            w_ready = 1'b0;
   t_mem_w          w;
   logic            b_valid = 1'b0;
   logic            b_ready;
   logic            done_valid;
   t_dma_done       done;
   t_dma_status     status;

   t_dma_descriptor descs[$];
   logic [63:0]     src_mem [logic [31:0]];
   logic [63:0]     dst_mem [logic [31:0]];
   logic [31:0]     rng;
   logic [31:0]     rd_addr = '0;
   t_dma_descriptor wr_desc = '0;
   int              rd_left = 0;
   int              wr_beat = 0;
   int              b_owed = 0;
   int              ar_idx = 0;
   int              aw_idx = 0;
   int              done_idx = 0;
   int              errors = 0;
   int              limit = 0;

   dma_copy_top i_dut (.*);

   always #2 clk = ~clk;

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      return y ^ (y << 5);
   endfunction

   function automatic logic [31:0] next_rand();
      rng = xorshift(rng);
      return rng;
   endfunction

   function automatic logic coin();
      logic [31:0] v;
      v = next_rand();
      return v[9];
   endfunction

   function automatic int beat_count(input t_dma_descriptor d);
      return (d.length == '0) ? 256 : int'(d.length);   // zero encodes 256 beats.
   endfunction

   function automatic logic [31:0] beat_addr(input logic [31:0] base, input int beat);
      return base + 32'(beat * 8);
   endfunction

   task automatic check_data(input t_mem_w got, input t_mem_w exp);
      if (got !== exp) begin
         errors++;
         $display("FAIL %0t: w beat %h last %b, expected %h last %b",
                  $time, got.data, got.last, exp.data, exp.last);
      end
   endtask

   task automatic check_done(input t_dma_done got, input t_dma_done exp);
      if (got !== exp) begin
         errors++;
         $display("FAIL %0t: done tag %h, expected %h", $time, got.tag, exp.tag);
      end
   endtask

   task automatic check_status(input t_dma_status got, input t_dma_status exp);
      if (got !== exp) begin
         errors++;
         $display("FAIL %0t: status busy %b completed %0d, expected busy %b completed %0d",
                  $time, got.busy, got.completed, exp.busy, exp.completed);
      end
   endtask

   task automatic check_ar(input t_mem_ar got, input t_mem_ar exp);
      if (got !== exp) begin
         errors++;
         $display("FAIL %0t: ar %h len %h, expected %h len %h",
                  $time, got.addr, got.len, exp.addr, exp.len);
      end
   endtask

   task automatic check_aw(input t_mem_aw got, input t_mem_aw exp);
      if (got !== exp) begin
         errors++;
         $display("FAIL %0t: aw %h len %h, expected %h len %h",
                  $time, got.addr, got.len, exp.addr, exp.len);
      end
   endtask

   task automatic load_descriptors();
      int              fd;
      string           line;
      logic [31:0]     s;
      logic [31:0]     d;
      logic [31:0]     l;
      logic [31:0]     t;
      t_dma_descriptor entry;
      fd = $fopen("verif/dma_copy_input.txt", "r");
      if (fd == 0) begin
         errors++;
         $display("could not open verif/dma_copy_input.txt");
      end else begin
         while ($fgets(line, fd) > 0) begin
            if ($sscanf(line, "%h %h %h %h", s, d, l, t) == 4) begin   // comment lines fail here.
               entry.src_addr = s;
               entry.dst_addr = d;
               entry.length   = l[`DMA_LEN_W-1:0];
               entry.tag      = t[`DMA_TAG_W-1:0];
               descs.push_back(entry);
            end
         end
         $fclose(fd);
      end
   endtask

   task automatic fill_source();
      logic [31:0] a;
      logic [31:0] hi;
      logic [31:0] lo;
      foreach (descs[i]) begin
         for (int b = 0; b < beat_count(descs[i]); b++) begin
            a  = beat_addr(descs[i].src_addr, b);
            hi = next_rand();
            lo = next_rand() ^ a;   // the low half also carries the address.
            src_mem[a] = {hi, lo};
         end
      end
   endtask

   task automatic take_read_addr();
      t_mem_ar exp;
      int      n;
      if (ar_idx >= descs.size()) begin
         errors++;
         $display("a read burst was issued with no descriptor left");
      end else begin
         n        = beat_count(descs[ar_idx]) - 1;
         exp.addr = descs[ar_idx].src_addr;
         exp.len  = n[`DMA_LEN_W-1:0];
         check_ar(ar, exp);
         rd_addr = ar.addr;
         rd_left = int'(ar.len) + 1;
         ar_idx++;
      end
   endtask

   task automatic take_write_addr();
      t_mem_aw exp;
      int      n;
      if (aw_idx >= descs.size()) begin
         errors++;
         $display("a write burst was issued with no descriptor left");
      end else begin
         wr_desc  = descs[aw_idx];
         n        = beat_count(wr_desc) - 1;
         exp.addr = wr_desc.dst_addr;
         exp.len  = n[`DMA_LEN_W-1:0];
         check_aw(aw, exp);
         wr_beat = 0;
         aw_idx++;
      end
   endtask

   task automatic take_write_beat();
      t_mem_w      exp;
      logic [31:0] a;
      a        = beat_addr(wr_desc.dst_addr, wr_beat);
      exp.data = src_mem[beat_addr(wr_desc.src_addr, wr_beat)];
      exp.last = (wr_beat == beat_count(wr_desc) - 1);
      check_data(w, exp);
      if (dst_mem.exists(a)) begin
         errors++;
         $display("destination word at %h was written twice", a);
      end
      dst_mem[a] = w.data;
      wr_beat++;
      if (w.last) b_owed++;
   endtask

   task automatic take_done();
      t_dma_done   exp;
      t_dma_status exp_st;
      if (done_idx >= descs.size()) begin
         errors++;
         $display("a completion pulse arrived with no copy left");
      end else begin
         exp.tag = descs[done_idx].tag;
         check_done(done, exp);
         done_idx++;
         exp_st.busy      = 1'b1;
         exp_st.completed = 8'(done_idx);
         check_status(status, exp_st);
      end
   endtask

   task automatic check_destination();
      logic [31:0] a;
      foreach (descs[i]) begin
         for (int b = 0; b < beat_count(descs[i]); b++) begin
            a = beat_addr(descs[i].dst_addr, b);
            if (!dst_mem.exists(a)) begin
               errors++;
               $display("destination word at %h was never written", a);
            end
         end
      end
   endtask

   // Handshakes are sampled mid-cycle and answered just after the next edge.
   always begin : memory_models
      logic ar_fire;
      logic r_fire;
      logic aw_fire;
      logic w_fire;
      logic b_fire;
      @(negedge clk);
      ar_fire = ar_valid && ar_ready;
      r_fire  = r_valid && r_ready;
      aw_fire = aw_valid && aw_ready;
      w_fire  = w_valid && w_ready;
      b_fire  = b_valid && b_ready;
      if (ar_fire) take_read_addr();
      if (r_fire) begin
         rd_addr = rd_addr + 32'd8;
         rd_left--;
      end
      if (aw_fire) take_write_addr();
      if (w_fire) take_write_beat();
      if (b_fire) b_owed--;
      if (ar_idx > done_idx && !status.busy) begin
         errors++;
         $display("FAIL %0t: status.busy low while a copy is in flight", $time);
      end
      if (done_valid) take_done();
      @(posedge clk);
      #0.5;
      ar_ready = coin();
      aw_ready = coin();
      w_ready  = coin();
      if (r_fire) r_valid = 1'b0;
      if (!r_valid && rd_left > 0 && coin()) begin
         r_valid = 1'b1;
         r.data  = src_mem[rd_addr];
         r.last  = (rd_left == 1);
      end
      if (b_fire) b_valid = 1'b0;
      if (!b_valid && b_owed > 0 && coin()) b_valid = 1'b1;
   end

   initial begin
      int          total;
      logic        accepted;
      t_dma_status exp_st;
      rng = 32'h8a7d_8452;
      load_descriptors();
      fill_source();
      total = 0;
      foreach (descs[i]) total += beat_count(descs[i]);
      limit = 400 * total + 1000;
      repeat (15) @(posedge clk);
      @(negedge clk);
      if (ar_valid || r_ready || aw_valid || w_valid || b_ready || done_valid) begin
         errors++;
         $display("FAIL %0t: a handshake output is high during reset", $time);
      end
      exp_st = '0;
      check_status(status, exp_st);
      @(posedge clk);
      #0.5;
      reset_n = 1'b1;
      foreach (descs[i]) begin
         desc_valid = 1'b1;
         desc       = descs[i];
         do begin
            @(negedge clk);
            accepted = desc_ready;
            @(posedge clk);
            #0.5;
         end while (!accepted);
      end
      desc_valid = 1'b0;
      while (done_idx < descs.size()) @(posedge clk);
      @(negedge clk);   // the engine is idle on the cycle after the last pulse.
      exp_st.busy      = 1'b0;
      exp_st.completed = 8'(descs.size());
      check_status(status, exp_st);
      check_destination();
      $display("errors: %0d", errors);
      if (errors == 0) $display("ALL CHECKS PASSED");
      else $display("CHECKS FAILED");
      $finish;
   end

   initial begin : watchdog
      wait (limit > 0);
      repeat (limit) @(posedge clk);
      $display("timeout: the copies did not complete within %0d cycles", limit);
      $display("CHECKS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

/* dma_copy_top.f */
+incdir+hdl
hdl/dma_pkg.sv
hdl/dma_sync_fifo.sv
hdl/dma_read_fsm.sv
hdl/dma_write_fsm.sv
hdl/dma_copy_top.sv
verif/dma_copy_chk.sv
verif/dma_copy_tb.sv

/* Makefile */
TOP := dma_copy_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f dma_copy_top.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f dma_copy_top.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir

/* verif/dma_copy_input.txt */
// src_addr dst_addr length tag, all in hex, one copy per line.
// length counts 64-bit beats.
10000000 20000400 01 3
10000100 20000000 04 a
10000200 20000900 08 5
10000300 20000100 10 c
10000400 20000600 03 1
10000500 20000200 0c 7
10000600 20000800 02 e
10000700 20000300 09 0
10000800 20000500 05 9
10000900 20000700 07 f
